// ==== seq_system.f ====
seq_isa_pkg.sv
seq_bus_pkg.sv
seq_program_mem.sv
seq_decode.sv
seq_execute.sv
seq_result.sv
seq_system.sv
tb_clock_gen.sv
tb_seq_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
      --top-module tb_seq_system -Mdir obj_dir -o sim_tb -f seq_system.f; then
   echo "build failed"
   exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== tb_seq_system.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_seq_system;
   import seq_isa_pkg::*;
   import seq_bus_pkg::*;

   // expected effect of one clock edge
   typedef struct packed {
      seq_state_t state;
      logic [7:0] next_addr;
      seq_cmd_t   oreg;
      logic [7:0] oreg_wen;
   } expect_t;

   // setup, tests 1 to 5, then margin
   localparam int cycle_limit = 262 + 30 + 31 + 105 + 138 + 25 + 200;

   logic       clock;
   logic       reset;
   logic       run;
   logic       prog_wen;
   logic [7:0] prog_addr;
   seq_inst_t  prog_data;
   logic [7:0] ireg [4];
   logic [7:0] next;
   logic       error;
   seq_cmd_t   oreg;
   logic [7:0] oreg_wen;
   seq_cmd_t   dev_cmd [8];

   seq_inst_t  prog [256];  // copy of the program memory
   seq_state_t m_state;
   logic [7:0] m_addr;
   seq_cmd_t   m_oreg;
   logic [7:0] m_wen;
   seq_cmd_t   m_dev [8];
   int         test_err;
   int         pass_count;
   int         fail_count;

   tb_clock_gen u_clock (.clock(clock));

   seq_system DUT (
      .clock     (clock),
      .reset     (reset),
      .run       (run),
      .prog_wen  (prog_wen),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .ireg      (ireg),
      .next      (next),
      .error     (error),
      .oreg      (oreg),
      .oreg_wen  (oreg_wen),
      .dev_cmd   (dev_cmd)
   );

   // one edge of the sequencer, from the instruction set rules
   function automatic expect_t ref_step(logic [7:0] addr, seq_state_t st, logic go,
                                        logic [3:0][7:0] regs, seq_inst_t inst);
      expect_t    r;
      logic [7:0] src;
      logic [7:0] plus1;
      r           = '0;
      r.state     = st;
      r.next_addr = addr;
      src         = regs[inst.lo[1:0]];
      plus1       = addr + 8'd1;
      if (st == st_reset) begin
         r.state     = st_ready;
         r.next_addr = 8'd0;
      end else if (st == st_error) begin
         r.next_addr = 8'd0;  // sticky until reset
      end else if (go) begin
         case (inst.opcode)
            op_no: r.next_addr = plus1;
            op_ci, op_cr: begin
               r.next_addr = plus1;
               r.oreg.cmd  = inst.hi[3:0];
               r.oreg.arg  = (inst.opcode == op_cr) ? src : inst.lo;
               r.oreg_wen  = 8'd1 << inst.hi[6:4];
            end
            op_ji: r.next_addr = inst.hi;
            op_jr: r.next_addr = src;
            op_jz: r.next_addr = (src == 8'd0) ? inst.hi : plus1;
            op_jn: r.next_addr = (src != 8'd0) ? inst.hi : plus1;
            default: begin
               r.state     = st_error;
               r.next_addr = 8'd0;
            end
         endcase
      end
      return r;
   endfunction

   function automatic seq_inst_t encode(logic [3:0] op, logic [7:0] hi, logic [7:0] lo);
      return {op, hi, lo};
   endfunction

   function automatic logic [7:0] rand_byte();
      return 8'($urandom());
   endfunction

   // ci or cr with random device, command and argument
   function automatic seq_inst_t rand_command();
      return encode((($urandom() & 1) != 0) ? op_cr : op_ci, rand_byte(), rand_byte());
   endfunction

   task automatic update_model();
      expect_t e;
      if (reset) begin
         m_state = st_reset;
         m_addr  = 8'd0;
         m_oreg  = '0;
         m_wen   = 8'd0;
         for (int d = 0; d < 8; d++) m_dev[d] = '0;
      end else begin
         e = ref_step(m_addr, m_state, run, {ireg[3], ireg[2], ireg[1], ireg[0]},
                      prog[m_addr]);
         m_state = e.state;
         m_addr  = e.next_addr;
         m_oreg  = e.oreg;
         m_wen   = e.oreg_wen;
         for (int d = 0; d < 8; d++) begin
            if (e.oreg_wen[d]) m_dev[d] = e.oreg;
         end
      end
   endtask

   task automatic report_mismatch(string name, logic [11:0] got, logic [11:0] exp);
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
      test_err++;
   endtask

   task automatic check_outputs();
      assert (next == m_addr) else report_mismatch("next", 12'(next), 12'(m_addr));
      assert (error == (m_state == st_error))
         else report_mismatch("error", 12'(error), 12'(m_state == st_error));
      assert (oreg == m_oreg) else report_mismatch("oreg", oreg, m_oreg);
      assert (oreg_wen == m_wen) else report_mismatch("oreg_wen", 12'(oreg_wen), 12'(m_wen));
      for (int d = 0; d < 8; d++) begin
         assert (dev_cmd[d] == m_dev[d])
            else report_mismatch($sformatf("dev_cmd[%0d]", d), dev_cmd[d], m_dev[d]);
      end
   endtask

   // model steps on the edge and the DUT is sampled 1 ns later
   initial begin : compare
      forever begin
         @(posedge clock);
         update_model();
         #1;
         check_outputs();
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clock);
         cycles++;
      end
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic cycle();
      @(posedge clock);
      #2;
   endtask

   task automatic load_word(input logic [7:0] addr, input seq_inst_t inst);
      prog[addr] = inst;
      prog_wen   = 1'b1;
      prog_addr  = addr;
      prog_data  = inst;
      cycle();
      prog_wen   = 1'b0;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      run   = 1'b0;
      repeat (5) cycle();
      reset = 1'b0;
      cycle();  // the one st_reset cycle
   endtask

   task automatic run_cycles(input int n);
      run = 1'b1;
      repeat (n) cycle();
      run = 1'b0;
   endtask

   task automatic randomize_regs(input logic with_zeros);
      for (int r = 0; r < 4; r++) begin
         ireg[r] = rand_byte();
         if (with_zeros && ($urandom() % 3 == 0)) ireg[r] = 8'd0;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_err == 0) begin
         pass_count++;
         $display("%s: ok", name);
      end else begin
         fail_count++;
         $display("%s: %0d mismatches", name, test_err);
      end
      test_err = 0;
   endtask

   initial begin : stimulus
      logic [7:0] a;
      int         k;
      void'($urandom(32'hd2e406ae));
      reset      = 1'b1;
      run        = 1'b0;
      prog_wen   = 1'b0;
      prog_addr  = 8'd0;
      prog_data  = '0;
      test_err   = 0;
      pass_count = 0;
      fail_count = 0;
      for (int r = 0; r < 4; r++) ireg[r] = 8'd0;
      apply_reset();
      for (int i = 0; i < 256; i++) begin  // ci everywhere with fields from the address
         a = 8'(i);
         load_word(a, encode(op_ci, {1'b0, a[2:0], a[7:4]}, a ^ 8'h5a));
      end

      for (int i = 0; i < 12; i++) load_word(8'(i), rand_command());
      randomize_regs(1'b0);
      apply_reset();
      run_cycles(12);
      finish_test("test 1 straight-line commands");

      k = int'($urandom() % 4);
      load_word(8'd0, rand_command());
      load_word(8'd1, rand_command());
      load_word(8'd2, encode(op_jr, rand_byte(), 8'(k)));
      load_word(8'h40, rand_command());
      load_word(8'h41, encode(op_ji, 8'h00, rand_byte()));  // back to the top
      randomize_regs(1'b0);
      ireg[k] = 8'h40;
      apply_reset();
      run_cycles(20);
      finish_test("test 2 ji and jr loop");

      // forward labels only so address 16 is always reached
      for (int i = 0; i < 16; i++) begin
         load_word(8'(i), encode((($urandom() & 1) != 0) ? op_jn : op_jz,
                                 8'(i + 1 + $urandom() % (16 - i)), rand_byte()));
      end
      load_word(8'd16, encode(op_ji, 8'hfe, 8'd0));
      load_word(8'hfe, rand_command());
      load_word(8'hff, encode(op_jn, 8'h05, 8'h03));  // reg 3 stays zero so this wraps
      apply_reset();
      run = 1'b1;
      repeat (80) begin
         randomize_regs(1'b1);
         ireg[3] = 8'd0;
         cycle();
      end
      run = 1'b0;
      finish_test("test 3 jz and jn branches");

      for (int i = 0; i < 32; i++) load_word(8'(i), rand_command());
      randomize_regs(1'b0);
      apply_reset();
      repeat (10) begin
         k   = 1 + int'($urandom() % 5);
         run = 1'b0;
         repeat (k) cycle();
         k   = 1 + int'($urandom() % 5);
         run = 1'b1;
         repeat (k) cycle();
      end
      run = 1'b0;
      finish_test("test 4 run gaps");

      load_word(8'd0, rand_command());
      load_word(8'd1, rand_command());
      load_word(8'd2, encode(4'(7 + $urandom() % 9), rand_byte(), rand_byte()));
      apply_reset();
      run_cycles(8);
      assert (error) else begin
         $display("error flag did not rise after an illegal opcode");
         test_err++;
      end
      apply_reset();
      run_cycles(2);  // stops short of the illegal word
      finish_test("test 5 illegal opcode");

      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clock
);

   localparam time half_period = 20ns;  // 40 ns clock

   initial begin
      clock = 1'b0;
      forever #half_period clock = ~clock;
   end

endmodule

`default_nettype wire

// ==== seq_system.sv ====
`timescale 1ns/100ps
`default_nettype none

module seq_system (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   run,
   input  logic                   prog_wen,
   input  logic [7:0]             prog_addr,
   input  seq_isa_pkg::seq_inst_t prog_data,
   input  logic [7:0]             ireg [4],
   output logic [7:0]             next,
   output logic                   error,
   output seq_bus_pkg::seq_cmd_t  oreg,
   output logic [7:0]             oreg_wen,
   output seq_bus_pkg::seq_cmd_t  dev_cmd [8]
);
   import seq_isa_pkg::*;
   import seq_bus_pkg::*;

   seq_inst_t       inst;    // fetched word
   seq_decoded_t    dec;
   seq_cmd_strobe_t strobe;  // execute -> result

   seq_program_mem u_mem (
      .clock     (clock),
      .prog_wen  (prog_wen),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .rd_addr   (next),
      .rd_inst   (inst)
   );

   seq_decode u_decode (
      .ireg (ireg),
      .inst (inst),
      .dec  (dec)
   );

   seq_execute u_execute (
      .clock  (clock),
      .reset  (reset),
      .run    (run),
      .dec    (dec),
      .next   (next),
      .error  (error),
      .strobe (strobe)
   );

   seq_result u_result (
      .clock    (clock),
      .reset    (reset),
      .strobe   (strobe),
      .oreg     (oreg),
      .oreg_wen (oreg_wen),
      .dev_cmd  (dev_cmd)
   );

endmodule

`default_nettype wire

// ==== seq_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module seq_result (
   input  logic                         clock,
   input  logic                         reset,
   input  seq_bus_pkg::seq_cmd_strobe_t strobe,
   output seq_bus_pkg::seq_cmd_t        oreg,
   output logic [7:0]                   oreg_wen,
   output seq_bus_pkg::seq_cmd_t        dev_cmd [8]
);

   // strobe is zero on idle cycles, so oreg_wen pulses for one cycle
   always_ff @(posedge clock) begin
      if (reset) begin
         oreg     <= '0;
         oreg_wen <= 8'd0;
      end else begin
         oreg     <= strobe.payload;
         oreg_wen <= strobe.dev_wen;
      end
   end

   // last command seen by each device
   for (genvar d = 0; d < 8; d++) begin : g_dev
      always_ff @(posedge clock) begin
         if (reset) begin
            dev_cmd[d] <= '0;
         end else if (strobe.dev_wen[d]) begin
            dev_cmd[d] <= strobe.payload;
         end
      end
   end

endmodule

`default_nettype wire

// ==== seq_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module seq_execute (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         run,
   input  seq_isa_pkg::seq_decoded_t    dec,
   output logic [7:0]                   next,
   output logic                         error,
   output seq_bus_pkg::seq_cmd_strobe_t strobe
);
   import seq_isa_pkg::*;
   import seq_bus_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;
   logic [7:0] addr;
   logic [7:0] addr_nxt;
   logic [7:0] addr_inc;
   logic       step;   // an instruction executes this cycle
   logic       issue;  // ci or cr goes out

   assign addr_inc = addr + 8'd1;  // wraps 255 -> 0
   assign step     = (state == st_ready) && run;
   assign issue    = step && !dec.illegal && (dec.op inside {op_ci, op_cr});

   always_comb begin
      state_nxt = state;
      addr_nxt  = addr;
      case (state)
         st_reset: begin
            state_nxt = st_ready;
            addr_nxt  = 8'd0;
         end
         st_ready: begin
            if (run && dec.illegal) begin
               state_nxt = st_error;
               addr_nxt  = 8'd0;
            end else if (run) begin
               case (dec.op)
                  op_ji: addr_nxt = dec.label;
                  op_jr: addr_nxt = dec.operand;
                  op_jz: addr_nxt = (dec.operand == 8'd0) ? dec.label : addr_inc;
                  op_jn: addr_nxt = (dec.operand != 8'd0) ? dec.label : addr_inc;
                  default: addr_nxt = addr_inc;  // no, ci, cr
               endcase
            end
         end
         default: begin
            // sticky until reset, also catches the unused code
            state_nxt = st_error;
            addr_nxt  = 8'd0;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= st_reset;
         addr  <= 8'd0;
      end else begin
         state <= state_nxt;
         addr  <= addr_nxt;
      end
   end

   // outgoing command, all zero unless issuing
   always_comb begin
      strobe = '0;
      if (issue) begin
         strobe.payload.cmd = dec.cmd;
         strobe.payload.arg = (dec.op == op_cr) ? dec.operand : dec.imm;
         strobe.dev_wen     = dec.dev_onehot;
      end
   end

   assign next  = addr;
   assign error = (state == st_error);

endmodule

`default_nettype wire

// ==== seq_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module seq_decode (
   input  logic [7:0]                ireg [4],
   input  seq_isa_pkg::seq_inst_t    inst,
   output seq_isa_pkg::seq_decoded_t dec
);
   import seq_isa_pkg::*;

   logic [2:0] dev_num;
   logic [1:0] src_sel;
   logic       bad_op;

   assign dev_num = inst.hi[6:4];  // hi[7] is spare
   assign src_sel = inst.lo[1:0];
   assign bad_op  = inst.opcode > 4'(op_jn);

   always_comb begin
      dec            = '0;
      dec.op         = seq_opcode_t'(inst.opcode);
      dec.illegal    = bad_op;
      dec.dev_onehot = 8'd1 << dev_num;
      dec.cmd        = inst.hi[3:0];
      dec.imm        = inst.lo;
      dec.label      = inst.hi;     // whole byte when used as a target
      dec.operand    = ireg[src_sel];
   end

endmodule

`default_nettype wire

// ==== seq_program_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module seq_program_mem (
   input  logic                   clock,
   input  logic                   prog_wen,
   input  logic [7:0]             prog_addr,
   input  seq_isa_pkg::seq_inst_t prog_data,
   input  logic [7:0]             rd_addr,
   output seq_isa_pkg::seq_inst_t rd_inst
);
   import seq_isa_pkg::*;

   seq_inst_t mem [256];  // program store

   // loaded before run goes high
   always_ff @(posedge clock) begin
      if (prog_wen) begin
         mem[prog_addr] <= prog_data;
      end
   end

   // fetch at the current sequencer address
   assign rd_inst = mem[rd_addr];

endmodule

`default_nettype wire

// ==== seq_bus_pkg.sv ====
`default_nettype none

package seq_bus_pkg;

   // sequencer FSM states, code 3 unused
   typedef enum logic [1:0] {
      st_reset = 2'd0,
      st_ready = 2'd1,
      st_error = 2'd2
   } seq_state_t;

   // 12-bit device command
   typedef struct packed {
      logic [3:0] cmd;
      logic [7:0] arg;
   } seq_cmd_t;

   // command plus per-device write enables
   typedef struct packed {
      seq_cmd_t   payload;
      logic [7:0] dev_wen;
   } seq_cmd_strobe_t;

endpackage

`default_nettype wire

// ==== seq_isa_pkg.sv ====
`default_nettype none

package seq_isa_pkg;

   // opcode field, values 7..15 are illegal
   typedef enum logic [3:0] {
      op_no = 4'd0,  // no operation
      op_ci = 4'd1,  // command, immediate arg
      op_cr = 4'd2,  // command, arg from input register
      op_ji = 4'd3,  // jump to label
      op_jr = 4'd4,  // jump to input register value
      op_jz = 4'd5,  // jump if register zero
      op_jn = 4'd6   // jump if register nonzero
   } seq_opcode_t;

   // 20-bit instruction word
   //   hi = {spare, dev[2:0], cmd[3:0]} or an 8-bit jump label
   //   lo = immediate arg, or source select in lo[1:0]
   typedef struct packed {
      logic [3:0] opcode;
      logic [7:0] hi;
      logic [7:0] lo;
   } seq_inst_t;

   // decode output, consumed by execute
   typedef struct packed {
      seq_opcode_t op;
      logic        illegal;
      logic [7:0]  dev_onehot;
      logic [3:0]  cmd;
      logic [7:0]  imm;         // argument for ci
      logic [7:0]  label;       // branch target
      logic [7:0]  operand;     // selected input register
   } seq_decoded_t;

endpackage

`default_nettype wire
